//--- logic/cnn_shape_pkg.sv
`default_nettype none

package cnn_shape_pkg;

	// input frame
	localparam int FRAME_WIDTH = 8;
	localparam int FRAME_HEIGHT = 8;

	// kernel
	localparam int KERNEL_SIZE = 3;
	localparam int KERNEL_TAPS = KERNEL_SIZE * KERNEL_SIZE;

	// channel counts
	localparam int IN_CH = 2;
	localparam int OUT_CH = 2;

	// result grid, valid windows only
	localparam int OUT_WIDTH = FRAME_WIDTH - KERNEL_SIZE + 1;
	localparam int OUT_HEIGHT = FRAME_HEIGHT - KERNEL_SIZE + 1;

	// coefficient stream, weights first then one bias per output channel
	localparam int WEIGHT_WORDS = OUT_CH * KERNEL_TAPS;
	localparam int COEF_WORDS = WEIGHT_WORDS + OUT_CH;

endpackage

`default_nettype wire

//--- logic/cnn_data_pkg.sv
`default_nettype none

package cnn_data_pkg;

	localparam int PIXEL_BITS = 8;
	localparam int PROD_BITS = 2 * PIXEL_BITS;
	localparam int ACC_BITS = 20;
	localparam int BIAS_BITS = 16;
	localparam int COORD_BITS = 3;
	localparam int COEF_CNT_BITS = $clog2(cnn_shape_pkg::COEF_WORDS);

	// one signed channel lane
	typedef logic signed [PIXEL_BITS-1:0] lane_t;

	// lane 0 in the low bits
	typedef lane_t [cnn_shape_pkg::IN_CH-1:0] pixel_t;
	typedef lane_t [cnn_shape_pkg::IN_CH-1:0] weight_t;

	typedef logic signed [BIAS_BITS-1:0] bias_t;
	typedef logic signed [PROD_BITS-1:0] prod_t;
	typedef logic signed [ACC_BITS-1:0] acc_t;

	// a coefficient word carries either per-lane weights or one bias
	typedef union packed {
		weight_t weight;
		bias_t   bias;
	} coef_word_u;

	// tap t sits at kernel row t/3, column t%3
	typedef pixel_t [cnn_shape_pkg::KERNEL_TAPS-1:0] window_t;

	typedef weight_t [cnn_shape_pkg::OUT_CH-1:0][cnn_shape_pkg::KERNEL_TAPS-1:0] weight_bank_t;
	typedef bias_t [cnn_shape_pkg::OUT_CH-1:0] bias_bank_t;
	typedef acc_t [cnn_shape_pkg::OUT_CH-1:0] acc_vec_t;

	typedef logic [COORD_BITS-1:0] coord_t;
	typedef logic [COEF_CNT_BITS-1:0] coef_cnt_t;

endpackage

`default_nettype wire

//--- logic/conv_if.sv
`default_nettype none

// window register to the multiply stage
interface window_if;

	logic                  valid;
	cnn_data_pkg::window_t taps;
	cnn_data_pkg::coord_t  row;
	cnn_data_pkg::coord_t  col;
	logic                  advance;

	modport source (
		output valid,
		output taps,
		output row,
		output col,
		input  advance
	);

	modport sink (
		input  valid,
		input  taps,
		input  row,
		input  col,
		output advance
	);

endinterface

// sum register to the output register
interface sum_if;

	logic                   valid;
	cnn_data_pkg::acc_vec_t sums;
	cnn_data_pkg::coord_t   row;
	cnn_data_pkg::coord_t   col;
	logic                   advance;

	modport source (
		output valid,
		output sums,
		output row,
		output col,
		input  advance
	);

	modport sink (
		input  valid,
		input  sums,
		input  row,
		input  col,
		output advance
	);

endinterface

`default_nettype wire

//--- logic/coef_decode.sv
`default_nettype none

module coef_decode (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       coef_valid,
	output logic                       coef_ready,
	input  cnn_data_pkg::coef_word_u   coef_data,
	output cnn_data_pkg::weight_bank_t weights,
	output cnn_data_pkg::bias_bank_t   biases,
	output logic                       coef_loaded
);

	cnn_data_pkg::coef_cnt_t coef_count;
	logic                    coef_accept;

	// one load per reset
	assign coef_ready = !coef_loaded;
	assign coef_accept = coef_valid && coef_ready;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			coef_count <= '0;
			coef_loaded <= 1'b0;
		end
		else if (coef_accept)
		begin
			coef_count <= coef_count + 1'b1;
			if (coef_count == cnn_data_pkg::coef_cnt_t'(cnn_shape_pkg::COEF_WORDS - 1))
			begin
				coef_loaded <= 1'b1;
			end
		end
	end

	// word o*9+t is a weight word, the last OUT_CH words are biases
	always_ff @(posedge clk)
	begin
		if (coef_accept)
		begin
			for (int o = 0; o < cnn_shape_pkg::OUT_CH; o++)
			begin
				for (int t = 0; t < cnn_shape_pkg::KERNEL_TAPS; t++)
				begin
					if (coef_count == cnn_data_pkg::coef_cnt_t'(o * cnn_shape_pkg::KERNEL_TAPS + t))
					begin
						weights[o][t] <= coef_data.weight;
					end
				end
			end
			for (int o = 0; o < cnn_shape_pkg::OUT_CH; o++)
			begin
				if (coef_count == cnn_data_pkg::coef_cnt_t'(cnn_shape_pkg::WEIGHT_WORDS + o))
				begin
					biases[o] <= coef_data.bias;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/window_builder.sv
`default_nettype none

module window_builder (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 coef_loaded,
	input  logic                 pixel_valid,
	output logic                 pixel_ready,
	input  cnn_data_pkg::pixel_t pixel_data,
	window_if.source             win
);

	// two rows back and one row back, indexed by column
	cnn_data_pkg::pixel_t row_top [cnn_shape_pkg::FRAME_WIDTH];
	cnn_data_pkg::pixel_t row_mid [cnn_shape_pkg::FRAME_WIDTH];

	cnn_data_pkg::coord_t row_cnt;
	cnn_data_pkg::coord_t col_cnt;
	logic                 pixel_accept;
	logic                 window_full;

	assign pixel_ready = coef_loaded && win.advance;
	assign pixel_accept = pixel_valid && pixel_ready;

	assign window_full =
		(row_cnt >= cnn_data_pkg::coord_t'(cnn_shape_pkg::KERNEL_SIZE - 1)) &&
		(col_cnt >= cnn_data_pkg::coord_t'(cnn_shape_pkg::KERNEL_SIZE - 1));

	// raster position of the next pixel
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			row_cnt <= '0;
			col_cnt <= '0;
		end
		else if (pixel_accept)
		begin
			if (col_cnt == cnn_data_pkg::coord_t'(cnn_shape_pkg::FRAME_WIDTH - 1))
			begin
				col_cnt <= '0;
				if (row_cnt == cnn_data_pkg::coord_t'(cnn_shape_pkg::FRAME_HEIGHT - 1))
				begin
					row_cnt <= '0;
				end
				else
				begin
					row_cnt <= row_cnt + 1'b1;
				end
			end
			else
			begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			win.valid <= 1'b0;
		end
		else if (win.advance)
		begin
			win.valid <= pixel_accept && window_full;
		end
	end

	// shift window left, new right column from the stores and the pixel
	always_ff @(posedge clk)
	begin
		if (pixel_accept)
		begin
			for (int k = 0; k < cnn_shape_pkg::KERNEL_SIZE; k++)
			begin
				for (int j = 0; j < cnn_shape_pkg::KERNEL_SIZE - 1; j++)
				begin
					win.taps[k * cnn_shape_pkg::KERNEL_SIZE + j] <=
						win.taps[k * cnn_shape_pkg::KERNEL_SIZE + j + 1];
				end
			end
			win.taps[cnn_shape_pkg::KERNEL_SIZE - 1] <= row_top[col_cnt];
			win.taps[2 * cnn_shape_pkg::KERNEL_SIZE - 1] <= row_mid[col_cnt];
			win.taps[cnn_shape_pkg::KERNEL_TAPS - 1] <= pixel_data;
			row_top[col_cnt] <= row_mid[col_cnt];
			row_mid[col_cnt] <= pixel_data;
			// top-left corner of the window
			win.row <= row_cnt - cnn_data_pkg::coord_t'(cnn_shape_pkg::KERNEL_SIZE - 1);
			win.col <= col_cnt - cnn_data_pkg::coord_t'(cnn_shape_pkg::KERNEL_SIZE - 1);
		end
	end

endmodule

`default_nettype wire

//--- logic/conv_execute.sv
`default_nettype none

module conv_execute (
	input  logic                       clk,
	input  logic                       rst,
	input  cnn_data_pkg::weight_bank_t weights,
	input  cnn_data_pkg::bias_bank_t   biases,
	window_if.sink                     win,
	sum_if.source                      sums
);

	cnn_data_pkg::prod_t prod [cnn_shape_pkg::OUT_CH][cnn_shape_pkg::KERNEL_TAPS]
		[cnn_shape_pkg::IN_CH];
	logic                 prod_valid;
	cnn_data_pkg::coord_t prod_row;
	cnn_data_pkg::coord_t prod_col;
	cnn_data_pkg::acc_t   tree_sum [cnn_shape_pkg::OUT_CH];

	// the whole pipeline moves together
	assign win.advance = sums.advance;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			prod_valid <= 1'b0;
			sums.valid <= 1'b0;
		end
		else if (sums.advance)
		begin
			prod_valid <= win.valid;
			sums.valid <= prod_valid;
		end
	end

	// stage one: every tap and lane product per output channel
	always_ff @(posedge clk)
	begin
		if (sums.advance)
		begin
			for (int o = 0; o < cnn_shape_pkg::OUT_CH; o++)
			begin
				for (int t = 0; t < cnn_shape_pkg::KERNEL_TAPS; t++)
				begin
					for (int i = 0; i < cnn_shape_pkg::IN_CH; i++)
					begin
						prod[o][t][i] <= win.taps[t][i] * weights[o][t][i];
					end
				end
			end
			prod_row <= win.row;
			prod_col <= win.col;
		end
	end

	// bias sign-extended, then all products
	always_comb
	begin
		for (int o = 0; o < cnn_shape_pkg::OUT_CH; o++)
		begin
			tree_sum[o] = biases[o];
			for (int t = 0; t < cnn_shape_pkg::KERNEL_TAPS; t++)
			begin
				for (int i = 0; i < cnn_shape_pkg::IN_CH; i++)
				begin
					tree_sum[o] = tree_sum[o] + prod[o][t][i];
				end
			end
		end
	end

	// stage two
	always_ff @(posedge clk)
	begin
		if (sums.advance)
		begin
			for (int o = 0; o < cnn_shape_pkg::OUT_CH; o++)
			begin
				sums.sums[o] <= tree_sum[o];
			end
			sums.row <= prod_row;
			sums.col <= prod_col;
		end
	end

endmodule

`default_nettype wire

//--- logic/result_writer.sv
`default_nettype none

module result_writer (
	input  logic                   clk,
	input  logic                   rst,
	sum_if.sink                    sums,
	output logic                   out_valid,
	input  logic                   out_ready,
	output cnn_data_pkg::acc_vec_t out_data,
	output cnn_data_pkg::coord_t   out_row,
	output cnn_data_pkg::coord_t   out_col,
	output logic                   out_last
);

	logic frame_end;

	// move on when the output register is free or being taken
	assign sums.advance = !out_valid || out_ready;

	assign frame_end = sums.valid &&
		(sums.row == cnn_data_pkg::coord_t'(cnn_shape_pkg::OUT_HEIGHT - 1)) &&
		(sums.col == cnn_data_pkg::coord_t'(cnn_shape_pkg::OUT_WIDTH - 1));

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			out_last <= 1'b0;
		end
		else if (sums.advance)
		begin
			out_valid <= sums.valid;
			out_last <= frame_end;
		end
	end

	// held while stalled
	always_ff @(posedge clk)
	begin
		if (sums.advance)
		begin
			out_data <= sums.sums;
			out_row <= sums.row;
			out_col <= sums.col;
		end
	end

endmodule

`default_nettype wire

//--- logic/conv_layer_top.sv
`default_nettype none

module conv_layer_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     coef_valid,
	output logic                     coef_ready,
	input  cnn_data_pkg::coef_word_u coef_data,
	input  logic                     pixel_valid,
	output logic                     pixel_ready,
	input  cnn_data_pkg::pixel_t     pixel_data,
	output logic                     out_valid,
	input  logic                     out_ready,
	output cnn_data_pkg::acc_vec_t   out_data,
	output cnn_data_pkg::coord_t     out_row,
	output cnn_data_pkg::coord_t     out_col,
	output logic                     out_last
);

	cnn_data_pkg::weight_bank_t weights;
	cnn_data_pkg::bias_bank_t   biases;
	logic                       coef_loaded;

	window_if win_bus ();
	sum_if    sum_bus ();

	coef_decode coef_decode_inst (
		.clk         (clk),
		.rst         (rst),
		.coef_valid  (coef_valid),
		.coef_ready  (coef_ready),
		.coef_data   (coef_data),
		.weights     (weights),
		.biases      (biases),
		.coef_loaded (coef_loaded)
	);

	window_builder window_builder_inst (
		.clk         (clk),
		.rst         (rst),
		.coef_loaded (coef_loaded),
		.pixel_valid (pixel_valid),
		.pixel_ready (pixel_ready),
		.pixel_data  (pixel_data),
		.win         (win_bus.source)
	);

	conv_execute conv_execute_inst (
		.clk     (clk),
		.rst     (rst),
		.weights (weights),
		.biases  (biases),
		.win     (win_bus.sink),
		.sums    (sum_bus.source)
	);

	result_writer result_writer_inst (
		.clk       (clk),
		.rst       (rst),
		.sums      (sum_bus.sink),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data),
		.out_row   (out_row),
		.out_col   (out_col),
		.out_last  (out_last)
	);

endmodule

`default_nettype wire

//--- testbench/conv_layer_model.svh
`ifndef CONV_LAYER_MODEL_SVH
`define CONV_LAYER_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'h9f80_0427;
localparam int FRAME_PIXELS = cnn_shape_pkg::FRAME_WIDTH * cnn_shape_pkg::FRAME_HEIGHT;
localparam int FRAME_RESULTS = cnn_shape_pkg::OUT_WIDTH * cnn_shape_pkg::OUT_HEIGHT;
localparam int LANE = cnn_data_pkg::PIXEL_BITS;
localparam int ACC = cnn_data_pkg::ACC_BITS;

// coefficient words and two frames, as sent
logic [15:0] coef_mem [cnn_shape_pkg::COEF_WORDS];
logic [15:0] frame_mem [2][FRAME_PIXELS];

// fibonacci taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	logic feedback;
	feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], feedback};
endfunction

// bias plus every tap and lane product, channel 0 in the low bits
function automatic logic [39:0] expected_result(input int frame, input int row, input int col);
	logic signed [19:0] acc;
	logic signed [15:0] bias;
	logic signed [7:0]  pixel_lane;
	logic signed [7:0]  weight_lane;
	logic [39:0]        result;
	int                 pixel_index;
	int                 word_index;
	result = '0;
	for (int o = 0; o < cnn_shape_pkg::OUT_CH; o++)
	begin
		bias = coef_mem[cnn_shape_pkg::WEIGHT_WORDS + o];
		acc = bias;
		for (int t = 0; t < cnn_shape_pkg::KERNEL_TAPS; t++)
		begin
			pixel_index = (row + t / cnn_shape_pkg::KERNEL_SIZE) * cnn_shape_pkg::FRAME_WIDTH
				+ col + t % cnn_shape_pkg::KERNEL_SIZE;
			word_index = o * cnn_shape_pkg::KERNEL_TAPS + t;
			for (int i = 0; i < cnn_shape_pkg::IN_CH; i++)
			begin
				pixel_lane = frame_mem[frame][pixel_index][LANE*i +: LANE];
				weight_lane = coef_mem[word_index][LANE*i +: LANE];
				acc = acc + pixel_lane * weight_lane;
			end
		end
		result[ACC*o +: ACC] = acc;
	end
	return result;
endfunction

`endif

//--- testbench/conv_layer_tb.sv
`default_nettype none

module conv_layer_tb;

	timeunit 1ns;
	timeprecision 1ns;

	localparam int HANDSHAKE_TIMEOUT = 200;
	localparam int RESULT_TIMEOUT = 3000;

	logic                     clk;
	logic                     rst;
	logic                     coef_valid;
	logic                     coef_ready;
	cnn_data_pkg::coef_word_u coef_data;
	logic                     pixel_valid;
	logic                     pixel_ready;
	cnn_data_pkg::pixel_t     pixel_data;
	logic                     out_valid;
	logic                     out_ready;
	cnn_data_pkg::acc_vec_t   out_data;
	cnn_data_pkg::coord_t     out_row;
	cnn_data_pkg::coord_t     out_col;
	logic                     out_last;

	`include "conv_layer_model.svh"

	logic [31:0] stim_lfsr;
	logic [31:0] ready_lfsr;
	logic        ready_random;
	logic        ones_phase;
	int          coef_accepted;
	int          result_count;
	int          expected_total;
	int          exp_frame;
	int          exp_row;
	int          exp_col;
	logic        exp_last;
	logic [39:0] exp_data;
	logic [46:0] held_out;

	conv_layer_top conv_layer_top_inst (
		.clk         (clk),
		.rst         (rst),
		.coef_valid  (coef_valid),
		.coef_ready  (coef_ready),
		.coef_data   (coef_data),
		.pixel_valid (pixel_valid),
		.pixel_ready (pixel_ready),
		.pixel_data  (pixel_data),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.out_data    (out_data),
		.out_row     (out_row),
		.out_col     (out_col),
		.out_last    (out_last)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// sink side applies random back-pressure only when enabled
	always @(posedge clk)
	begin
		#5;
		if (ready_random)
		begin
			ready_lfsr = lfsr_next(ready_lfsr);
			out_ready = ready_lfsr[0];
		end
		else
		begin
			out_ready = 1'b1;
		end
	end

	always @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			coef_accepted <= 0;
			result_count <= 0;
		end
		else
		begin
			if (coef_valid && coef_ready)
			begin
				coef_accepted <= coef_accepted + 1;
			end
			if (out_valid && out_ready)
			begin
				result_count <= result_count + 1;
			end
		end
	end

	// next result expected in row-major order
	always_comb
	begin
		exp_frame = (result_count / FRAME_RESULTS > 1) ? 1 : result_count / FRAME_RESULTS;
		exp_row = (result_count % FRAME_RESULTS) / cnn_shape_pkg::OUT_WIDTH;
		exp_col = (result_count % FRAME_RESULTS) % cnn_shape_pkg::OUT_WIDTH;
		exp_last = (exp_row == cnn_shape_pkg::OUT_HEIGHT - 1) &&
			(exp_col == cnn_shape_pkg::OUT_WIDTH - 1);
		exp_data = expected_result(exp_frame, exp_row, exp_col);
	end

	always @(posedge clk)
	begin
		held_out <= {out_last, out_row, out_col, out_data};
	end

	task automatic stop_on_failure();
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		$display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
		stop_on_failure();
	endtask

	task automatic report_problem(input string what);
		$display("ERROR: %s", what);
		stop_on_failure();
	endtask

	function automatic logic [15:0] random_bits(input int count);
		logic [15:0] bits;
		bits = '0;
		for (int k = 0; k < count; k++)
		begin
			stim_lfsr = lfsr_next(stim_lfsr);
			bits = {bits[14:0], stim_lfsr[0]};
		end
		return bits;
	endfunction

	// valid is already up and ready is read at the falling edge
	task automatic wait_accept(input bit is_pixel);
		int   waited;
		logic taken;
		waited = 0;
		taken = 1'b0;
		while (!taken)
		begin
			@(negedge clk);
			taken = is_pixel ? pixel_ready : coef_ready;
			@(posedge clk);
			#5;
			waited++;
			if (!taken && waited >= HANDSHAKE_TIMEOUT)
			begin
				report_problem(is_pixel ? "timed out waiting for pixel_ready"
					: "timed out waiting for coef_ready");
			end
		end
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (10) @(posedge clk);
		#5;
		rst = 1'b0;
	endtask

	task automatic load_coefs(input bit all_ones);
		logic [15:0] word;
		int          gap;
		for (int w = 0; w < cnn_shape_pkg::COEF_WORDS; w++)
		begin
			gap = random_bits(2);
			repeat (gap)
			begin
				@(posedge clk);
				#5;
			end
			if (all_ones)
			begin
				word = (w < cnn_shape_pkg::WEIGHT_WORDS) ? 16'h0101 : 16'h0000;
			end
			else
			begin
				word = random_bits(16);
				// channel 0 bias always negative
				if (w == cnn_shape_pkg::WEIGHT_WORDS)
				begin
					word[15] = 1'b1;
				end
			end
			coef_mem[w] = word;
			coef_data = word;
			coef_valid = 1'b1;
			wait_accept(1'b0);
			coef_valid = 1'b0;
		end
	endtask

	task automatic send_frame(input int frame, input bit all_ones);
		logic [15:0] word;
		for (int p = 0; p < FRAME_PIXELS; p++)
		begin
			word = all_ones ? 16'h0101 : random_bits(16);
			frame_mem[frame][p] = word;
			pixel_data = word;
			pixel_valid = 1'b1;
			wait_accept(1'b1);
			pixel_valid = 1'b0;
		end
	endtask

	task automatic wait_results(input int total);
		int waited;
		waited = 0;
		while (result_count < total)
		begin
			@(posedge clk);
			#5;
			waited++;
			if (result_count < total && waited >= RESULT_TIMEOUT)
			begin
				report_problem($sformatf("only %0d of %0d results arrived", result_count, total));
			end
		end
	endtask

	assert property (@(posedge clk) $fell(rst) |->
		({coef_ready, pixel_ready, out_valid, out_last} == 4'b1000))
	else report_mismatch("coef_ready,pixel_ready,out_valid,out_last",
		$sampled({coef_ready, pixel_ready, out_valid, out_last}), 64'h8);

	assert property (@(posedge clk) disable iff (rst)
		(coef_accepted < cnn_shape_pkg::COEF_WORDS) |-> !pixel_ready)
	else report_mismatch("pixel_ready", $sampled(pixel_ready), 64'h0);

	assert property (@(posedge clk) disable iff (rst)
		(coef_accepted < cnn_shape_pkg::COEF_WORDS) |-> coef_ready)
	else report_mismatch("coef_ready", $sampled(coef_ready), 64'h1);

	assert property (@(posedge clk) disable iff (rst)
		(coef_accepted == cnn_shape_pkg::COEF_WORDS) |-> !coef_ready)
	else report_mismatch("coef_ready", $sampled(coef_ready), 64'h0);

	assert property (@(posedge clk) disable iff (rst)
		out_valid |-> (result_count < expected_total))
	else report_problem("a result arrived after the last expected one");

	assert property (@(posedge clk) disable iff (rst) out_valid |-> (out_row == exp_row))
	else report_mismatch("out_row", $sampled(out_row), $sampled(exp_row));

	assert property (@(posedge clk) disable iff (rst) out_valid |-> (out_col == exp_col))
	else report_mismatch("out_col", $sampled(out_col), $sampled(exp_col));

	assert property (@(posedge clk) disable iff (rst) out_valid |-> (out_data == exp_data))
	else report_mismatch("out_data", $sampled(out_data), $sampled(exp_data));

	// out_last only ever marks result (5, 5)
	assert property (@(posedge clk) disable iff (rst) out_last == (out_valid && exp_last))
	else report_mismatch("out_last", $sampled(out_last), $sampled(out_valid && exp_last));

	// all-ones layer gives 9 taps times 2 lanes per channel
	assert property (@(posedge clk) disable iff (rst)
		(ones_phase && out_valid) |-> (out_data == {20'd18, 20'd18}))
	else report_mismatch("out_data", $sampled(out_data), {20'd18, 20'd18});

	assert property (@(posedge clk) disable iff (rst)
		(out_valid && !out_ready) |=> out_valid)
	else report_mismatch("out_valid", $sampled(out_valid), 64'h1);

	assert property (@(posedge clk) disable iff (rst)
		(out_valid && !out_ready) |=> ({out_last, out_row, out_col, out_data} == held_out))
	else report_mismatch("out_last,out_row,out_col,out_data",
		$sampled({out_last, out_row, out_col, out_data}), $sampled(held_out));

	initial
	begin
		rst = 1'b1;
		coef_valid = 1'b0;
		coef_data = '0;
		pixel_valid = 1'b0;
		pixel_data = '0;
		out_ready = 1'b1;
		ready_random = 1'b0;
		ones_phase = 1'b1;
		expected_total = 0;
		stim_lfsr = LFSR_SEED;
		ready_lfsr = LFSR_SEED;
		apply_reset();

		expected_total = FRAME_RESULTS;
		load_coefs(1'b1);
		send_frame(0, 1'b1);
		wait_results(FRAME_RESULTS);

		// random layer with two frames back to back and back-pressure on the second
		ones_phase = 1'b0;
		apply_reset();
		expected_total = 2 * FRAME_RESULTS;
		load_coefs(1'b0);
		send_frame(0, 1'b0);
		ready_random = 1'b1;
		send_frame(1, 1'b0);
		wait_results(2 * FRAME_RESULTS);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+testbench
logic/cnn_shape_pkg.sv
logic/cnn_data_pkg.sv
logic/conv_if.sv
logic/coef_decode.sv
logic/window_builder.sv
logic/conv_execute.sv
logic/result_writer.sv
logic/conv_layer_top.sv
testbench/conv_layer_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= conv_layer_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
